// ==== bench/ps_ctrl_assertions.sv ====
`timescale 1ns/100ps

module ps_ctrl_assertions (
    input logic clk,
    input logic rst_n,
    input logic awready,
    input logic wready,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic gie,
    input logic ier_done,
    input logic ap_done,
    input logic interrupt
);

    int fail_count = 0;

    // write response held until the master takes it
    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
    else begin
        fail_count++;
        $error("bvalid dropped before bready");
    end

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
    else begin
        fail_count++;
        $error("rvalid dropped before rready");
    end

    // address and data phases are separate states
    aw_w_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(awready && wready))
    else begin
        fail_count++;
        $error("awready and wready high together");
    end

    // an enabled done raises interrupt on the next cycle
    irq_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        gie && ier_done && ap_done |=> interrupt || !gie)
    else begin
        fail_count++;
        $error("interrupt not raised after an enabled done");
    end

endmodule

bind ps_ctrl_top ps_ctrl_assertions i_ps_ctrl_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .awready  (s_axi_awready),
    .wready   (s_axi_wready),
    .bvalid   (s_axi_bvalid),
    .bready   (s_axi_bready),
    .rvalid   (s_axi_rvalid),
    .rready   (s_axi_rready),
    .gie      (gie),
    .ier_done (ier.done),
    .ap_done  (ap_done),
    .interrupt(interrupt)
);

// ==== bench/tb_ps_ctrl.sv ====
`timescale 1ns/100ps

module tb_ps_ctrl
    import ps_ctrl_pkg::*;
();

    localparam int NUM_CORES   = 4;
    localparam int CORE_SEL_W  = $clog2(NUM_CORES);
    localparam int DRIVE_DELAY = 10;
    localparam int STALL_LIMIT = 16;

    localparam logic [1:0] K_WRITE = 2'd0;
    localparam logic [1:0] K_READ  = 2'd1;
    localparam logic [1:0] K_EVENT = 2'd2;

    localparam int F_AWREADY = 0;
    localparam int F_WREADY  = 1;
    localparam int F_BVALID  = 2;
    localparam int F_ARREADY = 3;
    localparam int F_RVALID  = 4;

    // one table row, ev is {ready, done}
    typedef struct packed {
        logic [1:0]  kind;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  ev;
        logic [31:0] exp_rd;
        logic        exp_start;
        logic        exp_irq;
    } step_t;

    logic clk;
    logic rst_n;
    logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
    logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
    logic s_axi_rvalid, s_axi_rready;
    logic [7:0]  s_axi_awaddr, s_axi_araddr;
    logic [31:0] s_axi_wdata, s_axi_rdata;
    logic [3:0]  s_axi_wstrb;
    logic [1:0]  s_axi_bresp, s_axi_rresp;
    logic ap_start, ap_done, ap_idle, ap_ready, interrupt;
    logic [NUM_CORES-1:0][31:0] core_scalar;
    logic [NUM_CORES-1:0][31:0] core_status;

    step_t  steps[$];
    logic   steps_loaded = 1'b0;
    integer seed;
    int     value_errors = 0;
    int     stall_errors = 0;
    int     assert_errors = 0;

    ps_ctrl_top #(
        .NUM_CORES (NUM_CORES),
        .ADDR_WIDTH(8)
    ) i_ps_ctrl_top (
        .clk(clk), .rst_n(rst_n),
        .s_axi_awvalid(s_axi_awvalid), .s_axi_awready(s_axi_awready),
        .s_axi_awaddr(s_axi_awaddr), .s_axi_wvalid(s_axi_wvalid),
        .s_axi_wready(s_axi_wready), .s_axi_wdata(s_axi_wdata),
        .s_axi_wstrb(s_axi_wstrb), .s_axi_bvalid(s_axi_bvalid),
        .s_axi_bready(s_axi_bready), .s_axi_bresp(s_axi_bresp),
        .s_axi_arvalid(s_axi_arvalid), .s_axi_arready(s_axi_arready),
        .s_axi_araddr(s_axi_araddr), .s_axi_rvalid(s_axi_rvalid),
        .s_axi_rready(s_axi_rready), .s_axi_rdata(s_axi_rdata),
        .s_axi_rresp(s_axi_rresp), .ap_start(ap_start), .ap_done(ap_done),
        .ap_idle(ap_idle), .ap_ready(ap_ready), .core_scalar(core_scalar),
        .core_status(core_status), .interrupt(interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        value_errors++;
    endtask

    function automatic logic flag_state(input int which);
        case (which)
            F_AWREADY: return s_axi_awready;
            F_WREADY:  return s_axi_wready;
            F_BVALID:  return s_axi_bvalid;
            F_ARREADY: return s_axi_arready;
            default:   return s_axi_rvalid;
        endcase
    endfunction

    task automatic wait_for(input int which, input string name);
        int n;
        n = 0;
        while (!flag_state(which) && n < STALL_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!flag_state(which)) begin
            $display("DUT never raised %s within %0d cycles at time %0t",
                     name, STALL_LIMIT, $time);
            stall_errors++;
        end
    endtask

    // random back-pressure of 0 to 3 cycles
    task automatic hold_off();
        int wait_cycles;
        wait_cycles = int'($unsigned($random(seed)) % 4);
        repeat (wait_cycles) next_cycle();
    endtask

    task automatic write_reg(input step_t s, input int i);
        logic [CORE_SEL_W-1:0] core;
        s_axi_awvalid = 1'b1;
        s_axi_awaddr  = s.addr;
        s_axi_wvalid  = 1'b1;
        s_axi_wdata   = s.data;
        s_axi_wstrb   = s.strb;
        wait_for(F_AWREADY, "awready");
        next_cycle();
        s_axi_awvalid = 1'b0;
        wait_for(F_WREADY, "wready");
        next_cycle();
        s_axi_wvalid = 1'b0;
        wait_for(F_BVALID, "bvalid");
        if (s_axi_bresp !== AXI_RESP_OKAY) begin
            report_mismatch($sformatf("step %0d bresp", i), 32'(s_axi_bresp), 32'(AXI_RESP_OKAY));
        end
        // scalar output already carries the merged word
        if (s.addr >= ADDR_CORE_SCALAR_BASE &&
            s.addr < ADDR_CORE_SCALAR_BASE + 8'(4 * NUM_CORES)) begin
            core = CORE_SEL_W'((s.addr - ADDR_CORE_SCALAR_BASE) >> 2);
            if (core_scalar[core] !== s.exp_rd) begin
                report_mismatch($sformatf("step %0d core_scalar[%0d]", i, core),
                                core_scalar[core], s.exp_rd);
            end
        end
        hold_off();
        s_axi_bready = 1'b1;
        next_cycle();
        s_axi_bready = 1'b0;
    endtask

    task automatic read_reg(input step_t s, input int i);
        s_axi_arvalid = 1'b1;
        s_axi_araddr  = s.addr;
        wait_for(F_ARREADY, "arready");
        next_cycle();
        s_axi_arvalid = 1'b0;
        wait_for(F_RVALID, "rvalid");
        hold_off();
        if (s_axi_rdata !== s.exp_rd) begin
            report_mismatch($sformatf("step %0d read 0x%02h", i, s.addr), s_axi_rdata, s.exp_rd);
        end
        if (s_axi_rresp !== AXI_RESP_OKAY) begin
            report_mismatch($sformatf("step %0d rresp", i), 32'(s_axi_rresp), 32'(AXI_RESP_OKAY));
        end
        s_axi_rready = 1'b1;
        next_cycle();
        s_axi_rready = 1'b0;
    endtask

    task automatic pulse_events(input logic [1:0] ev);
        ap_done  = ev[0];
        ap_ready = ev[1];
        next_cycle();
        ap_done  = 1'b0;
        ap_ready = 1'b0;
    endtask

    function automatic void add_step(input logic [1:0] kind, input logic [7:0] addr,
                                     input logic [31:0] data, input logic [3:0] strb,
                                     input logic [1:0] ev, input logic [31:0] exp_rd,
                                     input logic exp_start, input logic exp_irq);
        step_t st;
        st = '{kind, addr, data, strb, ev, exp_rd, exp_start, exp_irq};
        steps.push_back(st);
    endfunction

    task automatic build_table();
        // everything mapped reads zero after reset
        add_step(K_READ,  8'h00, 32'h0, 4'h0, 2'b00, 32'h0, 1'b0, 1'b0);
        add_step(K_READ,  8'h04, 32'h0, 4'h0, 2'b00, 32'h0, 1'b0, 1'b0);
        add_step(K_READ,  8'h08, 32'h0, 4'h0, 2'b00, 32'h0, 1'b0, 1'b0);
        add_step(K_READ,  8'h0c, 32'h0, 4'h0, 2'b00, 32'h0, 1'b0, 1'b0);
        add_step(K_READ,  8'h30, 32'h0, 4'h0, 2'b00, 32'h0, 1'b0, 1'b0);
        add_step(K_READ,  8'h34, 32'h0, 4'h0, 2'b00, 32'h0, 1'b0, 1'b0);
        add_step(K_READ,  8'h38, 32'h0, 4'h0, 2'b00, 32'h0, 1'b0, 1'b0);
        add_step(K_READ,  8'h3c, 32'h0, 4'h0, 2'b00, 32'h0, 1'b0, 1'b0);
        // scalars, full word then partial strobes
        add_step(K_WRITE, 8'h30, 32'h1122_3344, 4'hf, 2'b00, 32'h1122_3344, 1'b0, 1'b0);
        add_step(K_WRITE, 8'h30, 32'haabb_ccdd, 4'h1, 2'b00, 32'h1122_33dd, 1'b0, 1'b0);
        add_step(K_WRITE, 8'h30, 32'heeff_0000, 4'hc, 2'b00, 32'heeff_33dd, 1'b0, 1'b0);
        add_step(K_READ,  8'h30, 32'h0,         4'h0, 2'b00, 32'heeff_33dd, 1'b0, 1'b0);
        add_step(K_WRITE, 8'h34, 32'h0102_0304, 4'hf, 2'b00, 32'h0102_0304, 1'b0, 1'b0);
        add_step(K_WRITE, 8'h34, 32'h5566_7788, 4'h6, 2'b00, 32'h0166_7704, 1'b0, 1'b0);
        add_step(K_READ,  8'h34, 32'h0,         4'h0, 2'b00, 32'h0166_7704, 1'b0, 1'b0);
        add_step(K_WRITE, 8'h38, 32'h9abc_def0, 4'hf, 2'b00, 32'h9abc_def0, 1'b0, 1'b0);
        add_step(K_WRITE, 8'h38, 32'hffff_ffff, 4'h8, 2'b00, 32'hffbc_def0, 1'b0, 1'b0);
        add_step(K_READ,  8'h38, 32'h0,         4'h0, 2'b00, 32'hffbc_def0, 1'b0, 1'b0);
        add_step(K_WRITE, 8'h3c, 32'h1357_9bdf, 4'hf, 2'b00, 32'h1357_9bdf, 1'b0, 1'b0);
        add_step(K_WRITE, 8'h3c, 32'h0000_0000, 4'h3, 2'b00, 32'h1357_0000, 1'b0, 1'b0);
        add_step(K_READ,  8'h3c, 32'h0,         4'h0, 2'b00, 32'h1357_0000, 1'b0, 1'b0);
        add_step(K_READ,  8'h30, 32'h0,         4'h0, 2'b00, 32'heeff_33dd, 1'b0, 1'b0);
        // status words and holes in the map
        add_step(K_READ,  8'h40, 32'h0, 4'h0, 2'b00, 32'h5a00_0000, 1'b0, 1'b0);
        add_step(K_READ,  8'h44, 32'h0, 4'h0, 2'b00, 32'h5b01_0101, 1'b0, 1'b0);
        add_step(K_READ,  8'h48, 32'h0, 4'h0, 2'b00, 32'h5c02_0202, 1'b0, 1'b0);
        add_step(K_READ,  8'h4c, 32'h0, 4'h0, 2'b00, 32'h5d03_0303, 1'b0, 1'b0);
        add_step(K_READ,  8'h10, 32'h0, 4'h0, 2'b00, 32'h0, 1'b0, 1'b0);
        add_step(K_READ,  8'h50, 32'h0, 4'h0, 2'b00, 32'h0, 1'b0, 1'b0);
        add_step(K_READ,  8'hfc, 32'h0, 4'h0, 2'b00, 32'h0, 1'b0, 1'b0);
        // start then done, done bit clears on read
        add_step(K_WRITE, 8'h00, 32'h01, 4'h1, 2'b00, 32'h0,  1'b1, 1'b0);
        add_step(K_READ,  8'h00, 32'h0,  4'h0, 2'b00, 32'h01, 1'b1, 1'b0);
        add_step(K_EVENT, 8'h00, 32'h0,  4'h0, 2'b01, 32'h0,  1'b0, 1'b0);
        add_step(K_READ,  8'h00, 32'h0,  4'h0, 2'b00, 32'h02, 1'b0, 1'b0);
        add_step(K_READ,  8'h00, 32'h0,  4'h0, 2'b00, 32'h00, 1'b0, 1'b0);
        // auto restart keeps start up across done
        add_step(K_WRITE, 8'h00, 32'h81, 4'h1, 2'b00, 32'h0,  1'b1, 1'b0);
        add_step(K_EVENT, 8'h00, 32'h0,  4'h0, 2'b01, 32'h0,  1'b1, 1'b0);
        add_step(K_READ,  8'h00, 32'h0,  4'h0, 2'b00, 32'h83, 1'b1, 1'b0);
        add_step(K_READ,  8'h00, 32'h0,  4'h0, 2'b00, 32'h81, 1'b1, 1'b0);
        add_step(K_WRITE, 8'h00, 32'h00, 4'h1, 2'b00, 32'h0,  1'b1, 1'b0);
        add_step(K_EVENT, 8'h00, 32'h0,  4'h0, 2'b01, 32'h0,  1'b0, 1'b0);
        add_step(K_READ,  8'h00, 32'h0,  4'h0, 2'b00, 32'h02, 1'b0, 1'b0);
        add_step(K_READ,  8'h00, 32'h0,  4'h0, 2'b00, 32'h00, 1'b0, 1'b0);
        // done interrupt with gie and ier set
        add_step(K_WRITE, 8'h04, 32'h1, 4'h1, 2'b00, 32'h0, 1'b0, 1'b0);
        add_step(K_WRITE, 8'h08, 32'h1, 4'h1, 2'b00, 32'h0, 1'b0, 1'b0);
        add_step(K_READ,  8'h04, 32'h0, 4'h0, 2'b00, 32'h1, 1'b0, 1'b0);
        add_step(K_READ,  8'h08, 32'h0, 4'h0, 2'b00, 32'h1, 1'b0, 1'b0);
        add_step(K_EVENT, 8'h00, 32'h0, 4'h0, 2'b01, 32'h0, 1'b0, 1'b1);
        add_step(K_READ,  8'h0c, 32'h0, 4'h0, 2'b00, 32'h1, 1'b0, 1'b1);
        add_step(K_WRITE, 8'h0c, 32'h1, 4'h1, 2'b00, 32'h0, 1'b0, 1'b0);
        add_step(K_READ,  8'h0c, 32'h0, 4'h0, 2'b00, 32'h0, 1'b0, 1'b0);
        // ready is not enabled
        add_step(K_EVENT, 8'h00, 32'h0, 4'h0, 2'b10, 32'h0, 1'b0, 1'b0);
        // isr still sets with gie low
        add_step(K_WRITE, 8'h04, 32'h0, 4'h1, 2'b00, 32'h0, 1'b0, 1'b0);
        add_step(K_EVENT, 8'h00, 32'h0, 4'h0, 2'b01, 32'h0, 1'b0, 1'b0);
        add_step(K_READ,  8'h0c, 32'h0, 4'h0, 2'b00, 32'h1, 1'b0, 1'b0);
        add_step(K_WRITE, 8'h04, 32'h1, 4'h1, 2'b00, 32'h0, 1'b0, 1'b1);
        add_step(K_WRITE, 8'h0c, 32'h1, 4'h1, 2'b00, 32'h0, 1'b0, 1'b0);
        add_step(K_READ,  8'h00, 32'h0, 4'h0, 2'b00, 32'h2, 1'b0, 1'b0);
        add_step(K_READ,  8'h00, 32'h0, 4'h0, 2'b00, 32'h0, 1'b0, 1'b0);
    endtask

    initial begin
        wait (steps_loaded);
        repeat (steps.size() * 20) @(posedge clk);
        $display("watchdog expired, the test sequence did not finish in %0d cycles",
                 steps.size() * 20);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        step_t s;
        seed          = 32'h1dce_edb6;
        rst_n         = 1'b0;
        s_axi_awvalid = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_bready  = 1'b0;
        s_axi_arvalid = 1'b0;
        s_axi_araddr  = '0;
        s_axi_rready  = 1'b0;
        ap_done       = 1'b0;
        ap_idle       = 1'b0;
        ap_ready      = 1'b0;
        core_status   = {32'h5d03_0303, 32'h5c02_0202, 32'h5b01_0101, 32'h5a00_0000};
        build_table();
        steps_loaded = 1'b1;

        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        next_cycle();
        if (s_axi_awready !== 1'b1) begin
            report_mismatch("awready after reset", 32'(s_axi_awready), 32'd1);
        end
        if (s_axi_wready !== 1'b0) begin
            report_mismatch("wready after reset", 32'(s_axi_wready), 32'd0);
        end
        if (s_axi_arready !== 1'b1) begin
            report_mismatch("arready after reset", 32'(s_axi_arready), 32'd1);
        end
        if (s_axi_bvalid !== 1'b0) begin
            report_mismatch("bvalid after reset", 32'(s_axi_bvalid), 32'd0);
        end
        if (s_axi_rvalid !== 1'b0) begin
            report_mismatch("rvalid after reset", 32'(s_axi_rvalid), 32'd0);
        end
        if (ap_start !== 1'b0) begin
            report_mismatch("ap_start after reset", 32'(ap_start), 32'd0);
        end
        if (interrupt !== 1'b0) begin
            report_mismatch("interrupt after reset", 32'(interrupt), 32'd0);
        end

        foreach (steps[i]) begin
            s = steps[i];
            case (s.kind)
                K_WRITE: write_reg(s, i);
                K_READ:  read_reg(s, i);
                default: pulse_events(s.ev);
            endcase
            if (ap_start !== s.exp_start) begin
                report_mismatch($sformatf("step %0d ap_start", i), 32'(ap_start), 32'(s.exp_start));
            end
            if (interrupt !== s.exp_irq) begin
                report_mismatch($sformatf("step %0d interrupt", i), 32'(interrupt), 32'(s.exp_irq));
            end
        end

        next_cycle();
        assert_errors = i_ps_ctrl_top.i_ps_ctrl_assertions.fail_count;
        $display("errors: %0d value, %0d protocol, %0d assertion",
                 value_errors, stall_errors, assert_errors);
        if (value_errors + stall_errors + assert_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== hdl/ap_ctrl_regs.sv ====
`timescale 1ns/100ps

module ap_ctrl_regs
    import ps_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  reg_write_t    wr_req,
    input  logic          ctrl_read_pulse,
    // accelerator handshake
    input  logic          ap_done,
    input  logic          ap_idle,
    input  logic          ap_ready,
    output logic          ap_start,
    // register values for the read port
    output ap_ctrl_word_u ctrl_word,
    output logic          gie,
    output irq_bits_t     ier,
    output irq_bits_t     isr,
    output logic          interrupt
);

    ap_ctrl_word_u wr_word;
    irq_bits_t     wr_irq;
    logic          ctrl_wr;
    logic          gie_wr;
    logic          ier_wr;
    logic          isr_wr;

    logic          done_q;
    logic          idle_q;
    logic          ready_q;
    logic          auto_restart_q;

    // incoming data seen as control fields and as irq bits
    assign wr_word.raw = wr_req.data;
    assign wr_irq      = wr_req.data[$bits(irq_bits_t)-1:0];

    // only the low byte lane carries these registers
    assign ctrl_wr = wr_req.valid && wr_req.strb[0] && (wr_req.addr == ADDR_AP_CTRL);
    assign gie_wr  = wr_req.valid && wr_req.strb[0] && (wr_req.addr == ADDR_GIE);
    assign ier_wr  = wr_req.valid && wr_req.strb[0] && (wr_req.addr == ADDR_IER);
    assign isr_wr  = wr_req.valid && wr_req.strb[0] && (wr_req.addr == ADDR_ISR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ap_start       <= 1'b0;
            done_q         <= 1'b0;
            idle_q         <= 1'b0;
            ready_q        <= 1'b0;
            auto_restart_q <= 1'b0;
        end else begin
            // start held until done, unless auto restart keeps it up
            if (ctrl_wr && wr_word.bits.start) begin
                ap_start <= 1'b1;
            end else if (ap_done) begin
                ap_start <= auto_restart_q;
            end
            // clear on read, a new done takes priority
            if (ap_done) begin
                done_q <= 1'b1;
            end else if (ctrl_read_pulse) begin
                done_q <= 1'b0;
            end
            idle_q  <= ap_idle;
            ready_q <= ap_ready;
            if (ctrl_wr) begin
                auto_restart_q <= wr_word.bits.auto_restart;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gie <= 1'b0;
            ier <= '0;
            isr <= '0;
        end else begin
            if (gie_wr) begin
                gie <= wr_req.data[0];
            end
            if (ier_wr) begin
                ier <= wr_irq;
            end
            // events set, writes of 1 toggle
            if (ier.done && ap_done) begin
                isr.done <= 1'b1;
            end else if (isr_wr) begin
                isr.done <= isr.done ^ wr_irq.done;
            end
            if (ier.ready && ap_ready) begin
                isr.ready <= 1'b1;
            end else if (isr_wr) begin
                isr.ready <= isr.ready ^ wr_irq.ready;
            end
        end
    end

    always_comb begin
        ctrl_word                   = '0;
        ctrl_word.bits.start        = ap_start;
        ctrl_word.bits.done         = done_q;
        ctrl_word.bits.idle         = idle_q;
        ctrl_word.bits.ready        = ready_q;
        ctrl_word.bits.auto_restart = auto_restart_q;
    end

    assign interrupt = gie & (isr.done | isr.ready);

endmodule

// ==== hdl/axil_read_port.sv ====
`timescale 1ns/100ps

module axil_read_port
    import ps_ctrl_pkg::*;
#(
    parameter int NUM_CORES  = 4,
    parameter int ADDR_WIDTH = 8
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // ar channel
    input  logic                                 arvalid,
    output logic                                 arready,
    input  logic [ADDR_WIDTH-1:0]                araddr,
    // r channel
    output logic                                 rvalid,
    input  logic                                 rready,
    output logic [DATA_WIDTH-1:0]                rdata,
    output logic [1:0]                           rresp,
    // register sources
    input  ap_ctrl_word_u                        ctrl_word,
    input  logic                                 gie,
    input  irq_bits_t                            ier,
    input  irq_bits_t                            isr,
    input  logic [NUM_CORES-1:0][DATA_WIDTH-1:0] core_scalar,
    input  logic [NUM_CORES-1:0][DATA_WIDTH-1:0] core_status,
    output logic                                 ctrl_read_pulse
);

    localparam logic RD_IDLE = 1'b0;
    localparam logic RD_DATA = 1'b1;
    localparam int   IRQ_W   = $bits(irq_bits_t);

    // status block sits right after the last scalar
    localparam logic [ADDR_FIELD_WIDTH-1:0] STATUS_BASE =
        ADDR_CORE_SCALAR_BASE + ADDR_FIELD_WIDTH'(4 * NUM_CORES);

    logic                        state;
    logic                        ar_hs;
    logic [ADDR_FIELD_WIDTH-1:0] raddr;
    logic [DATA_WIDTH-1:0]       rd_word;

    assign arready = (state == RD_IDLE);
    assign rvalid  = (state == RD_DATA);
    assign rresp   = AXI_RESP_OKAY;
    assign ar_hs   = arvalid & arready;
    assign raddr   = ADDR_FIELD_WIDTH'(araddr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= RD_IDLE;
        end else if (state == RD_IDLE) begin
            if (arvalid) state <= RD_DATA;
        end else if (rready) begin
            state <= RD_IDLE;
        end
    end

    // unmapped offsets fall through as zero
    always_comb begin
        rd_word = '0;
        case (raddr)
            ADDR_AP_CTRL: rd_word = ctrl_word.raw;
            ADDR_GIE:     rd_word = {{(DATA_WIDTH-1){1'b0}}, gie};
            ADDR_IER:     rd_word = {{(DATA_WIDTH-IRQ_W){1'b0}}, ier};
            ADDR_ISR:     rd_word = {{(DATA_WIDTH-IRQ_W){1'b0}}, isr};
            default: begin
                for (int i = 0; i < NUM_CORES; i++) begin
                    if (raddr == ADDR_CORE_SCALAR_BASE + ADDR_FIELD_WIDTH'(4 * i)) begin
                        rd_word = core_scalar[i];
                    end
                    if (raddr == STATUS_BASE + ADDR_FIELD_WIDTH'(4 * i)) begin
                        rd_word = core_status[i];
                    end
                end
            end
        endcase
    end

    // data captured at acceptance and held while rvalid waits
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata <= rd_word;
        end
    end

    // lets the control block clear done on the same edge
    assign ctrl_read_pulse = ar_hs && (raddr == ADDR_AP_CTRL);

endmodule

// ==== hdl/axil_write_port.sv ====
`timescale 1ns/100ps

module axil_write_port
    import ps_ctrl_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // aw channel
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [ADDR_WIDTH-1:0] awaddr,
    // w channel
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic [STRB_WIDTH-1:0] wstrb,
    // b channel
    output logic                  bvalid,
    input  logic                  bready,
    output logic [1:0]            bresp,
    // register write request
    output reg_write_t            wr_req
);

    localparam logic [1:0] WR_IDLE = 2'd0;
    localparam logic [1:0] WR_DATA = 2'd1;
    localparam logic [1:0] WR_RESP = 2'd2;

    logic [1:0]            state;
    logic [1:0]            state_next;
    logic [ADDR_WIDTH-1:0] waddr;
    logic                  aw_hs;
    logic                  w_hs;

    assign awready = (state == WR_IDLE);
    assign wready  = (state == WR_DATA);
    assign bvalid  = (state == WR_RESP);
    assign bresp   = AXI_RESP_OKAY;

    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WR_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            WR_IDLE: if (awvalid) state_next = WR_DATA;
            WR_DATA: if (wvalid) state_next = WR_RESP;
            WR_RESP: if (bready) state_next = WR_IDLE;
            default: state_next = WR_IDLE;
        endcase
    end

    // address held until the data beat arrives
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            waddr <= awaddr;
        end
    end

    // request goes out in the same cycle as the w handshake
    assign wr_req.valid = w_hs;
    assign wr_req.addr  = ADDR_FIELD_WIDTH'(waddr);
    assign wr_req.data  = wdata;
    assign wr_req.strb  = wstrb;

endmodule

// ==== hdl/core_channel.sv ====
`timescale 1ns/100ps

module core_channel
    import ps_ctrl_pkg::*;
#(
    parameter int CORE_INDEX = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  reg_write_t            wr_req,
    output logic [DATA_WIDTH-1:0] scalar
);

    localparam int BYTE_W = DATA_WIDTH / STRB_WIDTH;

    // this channel's word in the scalar block
    localparam logic [ADDR_FIELD_WIDTH-1:0] SCALAR_ADDR =
        ADDR_CORE_SCALAR_BASE + ADDR_FIELD_WIDTH'(4 * CORE_INDEX);

    logic hit;

    assign hit = wr_req.valid && (wr_req.addr == SCALAR_ADDR);

    // unstrobed bytes keep their old value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scalar <= '0;
        end else if (hit) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (wr_req.strb[b]) begin
                    scalar[b*BYTE_W +: BYTE_W] <= wr_req.data[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

endmodule

// ==== hdl/ps_ctrl_pkg.sv ====
package ps_ctrl_pkg;

    // bus geometry
    localparam int DATA_WIDTH       = 32;
    localparam int STRB_WIDTH       = DATA_WIDTH / 8;
    localparam int ADDR_FIELD_WIDTH = 8;

    // system registers
    localparam logic [ADDR_FIELD_WIDTH-1:0] ADDR_AP_CTRL = 8'h00;
    localparam logic [ADDR_FIELD_WIDTH-1:0] ADDR_GIE     = 8'h04;
    localparam logic [ADDR_FIELD_WIDTH-1:0] ADDR_IER     = 8'h08;
    localparam logic [ADDR_FIELD_WIDTH-1:0] ADDR_ISR     = 8'h0c;

    // core scalars, one word per core; status words follow them
    localparam logic [ADDR_FIELD_WIDTH-1:0] ADDR_CORE_SCALAR_BASE = 8'h30;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // one accepted write, valid for a single cycle
    typedef struct packed {
        logic                        valid;
        logic [ADDR_FIELD_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]       data;
        logic [STRB_WIDTH-1:0]       strb;
    } reg_write_t;

    // control word layout at 0x00
    typedef struct packed {
        logic [31:8] rsvd_hi;
        logic        auto_restart;
        logic [6:4]  rsvd_lo;
        logic        ready;
        logic        idle;
        logic        done;
        logic        start;
    } ap_ctrl_bits_t;

    // fields on the register side, raw word on the bus side
    typedef union packed {
        ap_ctrl_bits_t         bits;
        logic [DATA_WIDTH-1:0] raw;
    } ap_ctrl_word_u;

    // shared by ier and isr
    typedef struct packed {
        logic ready;
        logic done;
    } irq_bits_t;

endpackage

// ==== hdl/ps_ctrl_top.sv ====
`timescale 1ns/100ps

module ps_ctrl_top
    import ps_ctrl_pkg::*;
#(
    parameter int NUM_CORES  = 4,
    parameter int ADDR_WIDTH = 8
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // axi4-lite slave
    input  logic                                 s_axi_awvalid,
    output logic                                 s_axi_awready,
    input  logic [ADDR_WIDTH-1:0]                s_axi_awaddr,
    input  logic                                 s_axi_wvalid,
    output logic                                 s_axi_wready,
    input  logic [DATA_WIDTH-1:0]                s_axi_wdata,
    input  logic [STRB_WIDTH-1:0]                s_axi_wstrb,
    output logic                                 s_axi_bvalid,
    input  logic                                 s_axi_bready,
    output logic [1:0]                           s_axi_bresp,
    input  logic                                 s_axi_arvalid,
    output logic                                 s_axi_arready,
    input  logic [ADDR_WIDTH-1:0]                s_axi_araddr,
    output logic                                 s_axi_rvalid,
    input  logic                                 s_axi_rready,
    output logic [DATA_WIDTH-1:0]                s_axi_rdata,
    output logic [1:0]                           s_axi_rresp,
    // accelerator side
    output logic                                 ap_start,
    input  logic                                 ap_done,
    input  logic                                 ap_idle,
    input  logic                                 ap_ready,
    output logic [NUM_CORES-1:0][DATA_WIDTH-1:0] core_scalar,
    input  logic [NUM_CORES-1:0][DATA_WIDTH-1:0] core_status,
    output logic                                 interrupt
);

    reg_write_t    wr_req;
    ap_ctrl_word_u ctrl_word;
    logic          gie;
    irq_bits_t     ier;
    irq_bits_t     isr;
    logic          ctrl_read_pulse;

    axil_write_port #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) i_axil_write_port (
        .clk    (clk),
        .rst_n  (rst_n),
        .awvalid(s_axi_awvalid),
        .awready(s_axi_awready),
        .awaddr (s_axi_awaddr),
        .wvalid (s_axi_wvalid),
        .wready (s_axi_wready),
        .wdata  (s_axi_wdata),
        .wstrb  (s_axi_wstrb),
        .bvalid (s_axi_bvalid),
        .bready (s_axi_bready),
        .bresp  (s_axi_bresp),
        .wr_req (wr_req)
    );

    ap_ctrl_regs i_ap_ctrl_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_req         (wr_req),
        .ctrl_read_pulse(ctrl_read_pulse),
        .ap_done        (ap_done),
        .ap_idle        (ap_idle),
        .ap_ready       (ap_ready),
        .ap_start       (ap_start),
        .ctrl_word      (ctrl_word),
        .gie            (gie),
        .ier            (ier),
        .isr            (isr),
        .interrupt      (interrupt)
    );

    // one scalar register per core, each decoding its own word
    for (genvar g = 0; g < NUM_CORES; g++) begin : g_core
        core_channel #(
            .CORE_INDEX(g)
        ) i_core_channel (
            .clk   (clk),
            .rst_n (rst_n),
            .wr_req(wr_req),
            .scalar(core_scalar[g])
        );
    end

    axil_read_port #(
        .NUM_CORES (NUM_CORES),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) i_axil_read_port (
        .clk            (clk),
        .rst_n          (rst_n),
        .arvalid        (s_axi_arvalid),
        .arready        (s_axi_arready),
        .araddr         (s_axi_araddr),
        .rvalid         (s_axi_rvalid),
        .rready         (s_axi_rready),
        .rdata          (s_axi_rdata),
        .rresp          (s_axi_rresp),
        .ctrl_word      (ctrl_word),
        .gie            (gie),
        .ier            (ier),
        .isr            (isr),
        .core_scalar    (core_scalar),
        .core_status    (core_status),
        .ctrl_read_pulse(ctrl_read_pulse)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run tb_ps_ctrl with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_ps_ctrl -f vlog.f -Mdir obj_dir -o tb_ps_ctrl_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_ps_ctrl_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    echo "testbench reported failure"
    exit 1
fi
echo "testbench run clean"
exit 0

// ==== vlog.f ====
hdl/ps_ctrl_pkg.sv
hdl/axil_write_port.sv
hdl/core_channel.sv
hdl/ap_ctrl_regs.sv
hdl/axil_read_port.sv
hdl/ps_ctrl_top.sv
bench/ps_ctrl_assertions.sv
bench/tb_ps_ctrl.sv
